// File: bench/coreCases.txt
// kind instr pc | retireValid retireRd retireData | redirectValid redirectPc
// kind 0 idle, 1 instruction, 2 random idle gap, f end of cases
// Immediate ops, LUI, AUIPC
1 00500093 00000100 0 00 00000000 0 00000000
1 00a0a113 00000104 0 00 00000000 0 00000000
1 fff0c193 00000108 1 01 00000005 0 00000000
1 00409213 0000010c 1 02 00000001 0 00000000
1 4021d293 00000110 1 03 fffffffa 0 00000000
1 01c1d313 00000114 1 04 00000050 0 00000000
1 123453b7 00000118 1 05 fffffffe 0 00000000
1 00001417 0000011c 1 06 0000000f 0 00000000
0 00000000 00000000 1 07 12345000 0 00000000
0 00000000 00000000 1 08 0000111c 0 00000000
2 00000000 00000000 0 00 00000000 0 00000000
// Register ops at distances 1 to 3, x0 write and read
1 004084b3 00000200 0 00 00000000 0 00000000
1 40148533 00000204 0 00 00000000 0 00000000
1 0064f5b3 00000208 1 09 00000055 0 00000000
1 00a4e633 0000020c 1 0a 00000050 0 00000000
1 0011a6b3 00000210 1 0b 00000005 0 00000000
1 0011b733 00000214 1 0c 00000055 0 00000000
1 00c6c7b3 00000218 1 0d 00000001 0 00000000
1 00279833 0000021c 1 0e 00000000 0 00000000
1 4021d8b3 00000220 1 0f 00000054 0 00000000
1 00285933 00000224 1 10 000000a8 0 00000000
1 00108033 00000228 1 11 fffffffd 0 00000000
1 00100a33 0000022c 1 12 00000054 0 00000000
0 00000000 00000000 0 00 00000000 0 00000000
0 00000000 00000000 1 14 00000005 0 00000000
2 00000000 00000000 0 00 00000000 0 00000000
// Branches, each followed by an addi to x21
1 00108863 00000300 0 00 00000000 0 00000000
1 00100a93 00000304 0 00 00000000 1 00000310
1 00109863 00000310 0 00 00000000 0 00000000
1 00200a93 00000314 0 00 00000000 0 00000000
1 0011c863 00000318 0 00 00000000 0 00000000
1 00300a93 0000031c 1 15 00000002 1 00000328
1 0011d863 00000328 0 00 00000000 0 00000000
1 00400a93 0000032c 0 00 00000000 0 00000000
1 fe30ece3 00000330 0 00 00000000 0 00000000
1 00500a93 00000334 1 15 00000004 1 00000328
1 0030f863 00000328 0 00 00000000 0 00000000
1 00600a93 0000032c 0 00 00000000 0 00000000
0 00000000 00000000 0 00 00000000 0 00000000
0 00000000 00000000 1 15 00000006 0 00000000
2 00000000 00000000 0 00 00000000 0 00000000
// JAL and JALR
1 02000b6f 00000400 0 00 00000000 0 00000000
1 00700b93 00000404 0 00 00000000 1 00000420
1 01150c67 00000420 1 16 00000404 0 00000000
1 00800b93 00000424 0 00 00000000 1 00000060
1 ffdc0ce7 00000060 1 18 00000424 0 00000000
1 00900b93 00000064 0 00 00000000 1 00000420
0 00000000 00000000 1 19 00000064 0 00000000
0 00000000 00000000 0 00 00000000 0 00000000
f 00000000 00000000 0 00 00000000 0 00000000

// File: project.f
design/corePkg.sv
design/decodeExecBus.sv
design/instrDecoder.sv
design/regFile.sv
design/decodeExecReg.sv
design/executeStage.sv
design/pipelineCore.sv
bench/coreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module coreTb -f project.f -o coreSim

# The simulator exits nonzero on $fatal, the log decides the result
./obj_dir/coreSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log

// File: bench/coreTb.sv
`timescale 1ns/1ns
`default_nettype none

module coreTb;

    localparam int Width     = 32;
    localparam int Fields    = 8;
    localparam int MaxLines  = 64;
    localparam int MaxCycles = 400;

    // JAL x1 that must stay a bubble while the strobe is low
    localparam logic [31:0] IdleWord = 32'h0080_00ef;

    logic                            clk;
    logic                            reset;
    logic                            instrValid;
    logic [Width-1:0]                instr;
    logic [Width-1:0]                pc;
    logic                            retireValid;
    logic [corePkg::RegAddrBits-1:0] retireRd;
    logic [Width-1:0]                retireData;
    logic                            redirectValid;
    logic [Width-1:0]                redirectPc;

    // Eight words per case line
    logic [31:0] cases [0:Fields*MaxLines-1];

    int   line;
    int   base;
    int   cycles;
    int   idle;
    logic finished;

    pipelineCore #(.Width(Width)) uut (
        .clk           (clk),
        .reset         (reset),
        .instrValid    (instrValid),
        .instr         (instr),
        .pc            (pc),
        .retireValid   (retireValid),
        .retireRd      (retireRd),
        .retireData    (retireData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    always #20 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            failRun($sformatf("MISMATCH time %0t ns: %s is %h, expected %h",
                              $time, name, got, want));
        end
    endtask

    // Drive at the rising edge, outputs settle by the falling edge
    task automatic stepCycle(input logic valid, input logic [Width-1:0] word,
                             input logic [Width-1:0] addr);
        @(posedge clk);
        instrValid <= valid;
        instr      <= word;
        pc         <= addr;
        @(negedge clk);
        cycles++;
    endtask

    task automatic checkOutputs(input logic [31:0] wantRetire, input logic [31:0] wantRd,
                                input logic [31:0] wantData, input logic [31:0] wantRedirect,
                                input logic [31:0] wantTarget);
        compare("retireValid", 32'(retireValid), wantRetire);
        if (wantRetire != 0) begin
            compare("retireRd", 32'(retireRd), wantRd);
            compare("retireData", retireData, wantData);
        end
        compare("redirectValid", 32'(redirectValid), wantRedirect);
        if (wantRedirect != 0) begin
            compare("redirectPc", redirectPc, wantTarget);
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        line       = 0;
        base       = 0;
        cycles     = 0;
        idle       = 0;
        finished   = 1'b0;
        void'($urandom(32'h7aa5_8a67));
        $readmemh("bench/coreCases.txt", cases);

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        while (!finished && cycles < MaxCycles) begin
            if (line >= MaxLines) begin
                failRun("case file has no end marker");
            end
            base = line * Fields;
            case (cases[base])
                32'h0, 32'h1: begin
                    stepCycle(cases[base][0], cases[base+1], cases[base+2]);
                    checkOutputs(cases[base+3], cases[base+4], cases[base+5],
                                 cases[base+6], cases[base+7]);
                    line++;
                end
                32'h2: begin
                    // Pipeline is drained here, so extra idle slots change nothing
                    idle = int'($urandom % 4) + 1;
                    repeat (idle) begin
                        stepCycle(1'b0, IdleWord, '0);
                        checkOutputs('0, '0, '0, '0, '0);
                    end
                    line++;
                end
                32'hf: finished = 1'b1;
                default: failRun($sformatf("unknown line kind %h in case file", cases[base]));
            endcase
        end

        if (finished) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            failRun($sformatf("timeout: case file not done after %0d cycles", MaxCycles));
        end
    end

endmodule

`default_nettype wire

// File: design/pipelineCore.sv
`timescale 1ns/1ns
`default_nettype none

module pipelineCore #(
    parameter int Width = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            instrValid,
    input  logic [Width-1:0]                instr,
    input  logic [Width-1:0]                pc,
    output logic                            retireValid,
    output logic [corePkg::RegAddrBits-1:0] retireRd,
    output logic [Width-1:0]                retireData,
    output logic                            redirectValid,
    output logic [Width-1:0]                redirectPc
);

    logic flush;

    decodeExecBus #(.Width(Width)) decBus ();
    decodeExecBus #(.Width(Width)) exeBus ();

    instrDecoder #(.Width(Width)) decoder (
        .instr      (instr),
        .pc         (pc),
        .instrValid (instrValid),
        .dec        (decBus.source)
    );

    // Register file writes from the retire port
    regFile #(.Width(Width)) registers (
        .clk       (clk),
        .reset     (reset),
        .rs1       (decBus.rs1),
        .rs2       (decBus.rs2),
        .rd1       (decBus.rd1),
        .rd2       (decBus.rd2),
        .writeEn   (retireValid),
        .writeAddr (retireRd),
        .writeData (retireData)
    );

    decodeExecReg #(.Width(Width)) pipeReg (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .dec   (decBus.sink),
        .exe   (exeBus.source)
    );

    executeStage #(.Width(Width)) execute (
        .clk           (clk),
        .reset         (reset),
        .exe           (exeBus.sink),
        .flush         (flush),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .retireValid   (retireValid),
        .retireRd      (retireRd),
        .retireData    (retireData)
    );

endmodule

`default_nettype wire

// File: design/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage #(
    parameter int Width = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    decodeExecBus.sink                      exe,
    output logic                            flush,
    output logic                            redirectValid,
    output logic [Width-1:0]                redirectPc,
    output logic                            retireValid,
    output logic [corePkg::RegAddrBits-1:0] retireRd,
    output logic [Width-1:0]                retireData
);

    localparam int ShiftBits = $clog2(Width);

    logic [Width-1:0]     srcA;
    logic [Width-1:0]     srcB;
    logic [Width-1:0]     aluA;
    logic [Width-1:0]     aluB;
    logic [Width-1:0]     aluResult;
    logic [Width-1:0]     result;
    logic [Width-1:0]     target;
    logic [ShiftBits-1:0] shamt;
    logic                 branchTaken;
    logic                 taken;
    logic                 wbValid;
    logic                 wbRegWrite;

    // Forward from writeback
    always_comb begin
        srcA = exe.rd1;
        srcB = exe.rd2;
        if (retireValid && retireRd == exe.rs1) begin
            srcA = retireData;
        end
        if (retireValid && retireRd == exe.rs2) begin
            srcB = retireData;
        end
    end

    assign aluA  = exe.aluSrcPc ? exe.pc : srcA;
    assign aluB  = exe.aluSrcImm ? exe.immExt : srcB;
    assign shamt = aluB[ShiftBits-1:0];

    always_comb begin
        case (exe.aluOp)
            corePkg::aluAdd:   aluResult = aluA + aluB;
            corePkg::aluSub:   aluResult = aluA - aluB;
            corePkg::aluSll:   aluResult = aluA << shamt;
            corePkg::aluSlt:   aluResult = Width'($signed(aluA) < $signed(aluB));
            corePkg::aluSltu:  aluResult = Width'(aluA < aluB);
            corePkg::aluXor:   aluResult = aluA ^ aluB;
            corePkg::aluSrl:   aluResult = aluA >> shamt;
            corePkg::aluSra:   aluResult = $unsigned($signed(aluA) >>> shamt);
            corePkg::aluOr:    aluResult = aluA | aluB;
            corePkg::aluAnd:   aluResult = aluA & aluB;
            corePkg::aluPassB: aluResult = aluB;
            default:           aluResult = '0;
        endcase
    end

    // Branch compare on the forwarded register operands
    always_comb begin
        case (exe.funct3)
            corePkg::F3Beq:  branchTaken = srcA == srcB;
            corePkg::F3Bne:  branchTaken = srcA != srcB;
            corePkg::F3Blt:  branchTaken = $signed(srcA) < $signed(srcB);
            corePkg::F3Bge:  branchTaken = $signed(srcA) >= $signed(srcB);
            corePkg::F3Bltu: branchTaken = srcA < srcB;
            corePkg::F3Bgeu: branchTaken = srcA >= srcB;
            default:         branchTaken = 1'b0;
        endcase
    end

    assign taken  = exe.valid && (exe.jump || (exe.branch && branchTaken));
    // JALR target comes from the ALU sum with bit 0 cleared
    assign target = exe.jalr ? {aluResult[Width-1:1], 1'b0} : exe.pc + exe.immExt;

    assign redirectValid = taken;
    assign redirectPc    = target;
    assign flush         = taken;

    assign result = (exe.resultSrc == corePkg::resPcPlus4) ? exe.pcPlus4 : aluResult;

    // Writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid    <= 1'b0;
            wbRegWrite <= 1'b0;
        end else begin
            wbValid    <= exe.valid;
            wbRegWrite <= exe.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        retireRd   <= exe.rd;
        retireData <= result;
    end

    assign retireValid = wbValid && wbRegWrite && retireRd != '0;

endmodule

`default_nettype wire

// File: design/decodeExecReg.sv
`timescale 1ns/1ns
`default_nettype none

module decodeExecReg #(
    parameter int Width = 32
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         flush,
    decodeExecBus.sink   dec,
    decodeExecBus.source exe
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            // Bubble
            exe.valid     <= 1'b0;
            exe.regWrite  <= 1'b0;
            exe.resultSrc <= corePkg::resAlu;
            exe.aluOp     <= corePkg::aluAdd;
            exe.aluSrcImm <= 1'b0;
            exe.aluSrcPc  <= 1'b0;
            exe.funct3    <= 3'b000;
            exe.jump      <= 1'b0;
            exe.branch    <= 1'b0;
            exe.jalr      <= 1'b0;

            exe.rd1       <= {Width{1'b0}};
            exe.rd2       <= {Width{1'b0}};
            exe.pc        <= {Width{1'b0}};
            exe.pcPlus4   <= {Width{1'b0}};
            exe.immExt    <= {Width{1'b0}};
            exe.rd        <= '0;

            exe.rs1       <= '0;
            exe.rs2       <= '0;
        end else begin
            // control
            exe.valid     <= dec.valid;
            exe.regWrite  <= dec.regWrite;
            exe.resultSrc <= dec.resultSrc;
            exe.aluOp     <= dec.aluOp;
            exe.aluSrcImm <= dec.aluSrcImm;
            exe.aluSrcPc  <= dec.aluSrcPc;
            exe.funct3    <= dec.funct3;
            exe.jump      <= dec.jump;
            exe.branch    <= dec.branch;
            exe.jalr      <= dec.jalr;

            // Operands and immediate
            exe.rd1       <= dec.rd1;
            exe.rd2       <= dec.rd2;
            exe.pc        <= dec.pc;
            exe.pcPlus4   <= dec.pcPlus4;
            exe.immExt    <= dec.immExt;
            exe.rd        <= dec.rd;

            // Source addresses for forwarding
            exe.rs1       <= dec.rs1;
            exe.rs2       <= dec.rs2;
        end
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile #(
    parameter int Width = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [corePkg::RegAddrBits-1:0] rs1,
    input  logic [corePkg::RegAddrBits-1:0] rs2,
    output logic [Width-1:0]                rd1,
    output logic [Width-1:0]                rd2,
    input  logic                            writeEn,
    input  logic [corePkg::RegAddrBits-1:0] writeAddr,
    input  logic [Width-1:0]                writeData
);

    logic [Width-1:0] regs [32];

    // x0 reads zero, a same-cycle write passes straight through
    function automatic logic [Width-1:0] readPort(input logic [corePkg::RegAddrBits-1:0] addr);
        logic [Width-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (writeEn && writeAddr == addr) begin
            value = writeData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        rd1 = readPort(rs1);
        rd2 = readPort(rs2);
    end

endmodule

`default_nettype wire

// File: design/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder #(
    parameter int Width = 32
) (
    input  logic [Width-1:0] instr,
    input  logic [Width-1:0] pc,
    input  logic             instrValid,
    decodeExecBus.source     dec
);

    corePkg::opcodeT  opcode;
    logic [2:0]       funct3;
    logic             funct7Alt;
    logic [Width-1:0] immI;
    logic [Width-1:0] immU;
    logic [Width-1:0] immB;
    logic [Width-1:0] immJ;

    // funct3 plus the funct7 alternate bit select the ALU operation
    function automatic corePkg::aluOpT aluDecode(input logic [2:0] f3, input logic alt);
        corePkg::aluOpT op;
        case (f3)
            3'b000:  op = alt ? corePkg::aluSub : corePkg::aluAdd;
            3'b001:  op = corePkg::aluSll;
            3'b010:  op = corePkg::aluSlt;
            3'b011:  op = corePkg::aluSltu;
            3'b100:  op = corePkg::aluXor;
            3'b101:  op = alt ? corePkg::aluSra : corePkg::aluSrl;
            3'b110:  op = corePkg::aluOr;
            default: op = corePkg::aluAnd;
        endcase
        return op;
    endfunction

    assign opcode    = corePkg::opcodeT'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7Alt = instr[30];

    // Sign-extended immediates
    assign immI = Width'($signed(instr[31:20]));
    assign immU = Width'($signed({instr[31:12], 12'b0}));
    assign immB = Width'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
    assign immJ = Width'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));

    always_comb begin
        dec.valid     = instrValid;
        dec.regWrite  = 1'b0;
        dec.resultSrc = corePkg::resAlu;
        dec.aluOp     = corePkg::aluAdd;
        dec.aluSrcImm = 1'b0;
        dec.aluSrcPc  = 1'b0;
        dec.funct3    = funct3;
        dec.jump      = 1'b0;
        dec.branch    = 1'b0;
        dec.jalr      = 1'b0;
        dec.immExt    = immI;

        case (opcode)
            corePkg::opReg: begin
                dec.regWrite = 1'b1;
                dec.aluOp    = aluDecode(funct3, funct7Alt);
            end
            corePkg::opImm: begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                // Only SRAI uses the alternate bit
                dec.aluOp     = aluDecode(funct3, funct7Alt && funct3 == 3'b101);
            end
            corePkg::opLui: begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.aluOp     = corePkg::aluPassB;
                dec.immExt    = immU;
            end
            corePkg::opAuipc: begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.aluSrcPc  = 1'b1;
                dec.immExt    = immU;
            end
            corePkg::opJal: begin
                dec.regWrite  = 1'b1;
                dec.resultSrc = corePkg::resPcPlus4;
                dec.jump      = 1'b1;
                dec.immExt    = immJ;
            end
            corePkg::opJalr: begin
                dec.regWrite  = 1'b1;
                dec.resultSrc = corePkg::resPcPlus4;
                dec.aluSrcImm = 1'b1;
                dec.jump      = 1'b1;
                dec.jalr      = 1'b1;
            end
            corePkg::opBranch: begin
                dec.branch = 1'b1;
                dec.immExt = immB;
            end
            // Unsupported opcode turns into a bubble
            default: dec.valid = 1'b0;
        endcase
    end

    assign dec.pc      = pc;
    assign dec.pcPlus4 = pc + Width'(4);
    assign dec.rd      = instr[11:7];
    assign dec.rs1     = instr[19:15];
    assign dec.rs2     = instr[24:20];

endmodule

`default_nettype wire

// File: design/decodeExecBus.sv
`timescale 1ns/1ns
`default_nettype none

interface decodeExecBus #(
    parameter int Width = 32
) ();

    // Control
    logic                 valid;
    logic                 regWrite;
    corePkg::resultSrcT   resultSrc;
    corePkg::aluOpT       aluOp;
    logic                 aluSrcImm;
    logic                 aluSrcPc;
    logic [2:0]           funct3;
    logic                 jump;
    logic                 branch;
    logic                 jalr;

    // Data
    logic [Width-1:0]     rd1;
    logic [Width-1:0]     rd2;
    logic [Width-1:0]     pc;
    logic [Width-1:0]     pcPlus4;
    logic [Width-1:0]     immExt;
    logic [corePkg::RegAddrBits-1:0] rd;

    // Hazard
    logic [corePkg::RegAddrBits-1:0] rs1;
    logic [corePkg::RegAddrBits-1:0] rs2;

    modport source (
        output valid, regWrite, resultSrc, aluOp, aluSrcImm, aluSrcPc, funct3,
               jump, branch, jalr, rd1, rd2, pc, pcPlus4, immExt, rd, rs1, rs2
    );

    modport sink (
        input  valid, regWrite, resultSrc, aluOp, aluSrcImm, aluSrcPc, funct3,
               jump, branch, jalr, rd1, rd2, pc, pcPlus4, immExt, rd, rs1, rs2
    );

endinterface

`default_nettype wire

// File: design/corePkg.sv
`default_nettype none

package corePkg;

    // Register address width
    localparam int RegAddrBits = 5;

    // RV32I major opcodes handled by this slice
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011
    } opcodeT;

    // ALU control, 5 bits wide
    typedef enum logic [4:0] {
        aluAdd   = 5'd0,
        aluSub   = 5'd1,
        aluSll   = 5'd2,
        aluSlt   = 5'd3,
        aluSltu  = 5'd4,
        aluXor   = 5'd5,
        aluSrl   = 5'd6,
        aluSra   = 5'd7,
        aluOr    = 5'd8,
        aluAnd   = 5'd9,
        // LUI passes the U immediate straight through
        aluPassB = 5'd10
    } aluOpT;

    // Writeback value select
    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resPcPlus4 = 2'd1
    } resultSrcT;

    // Branch funct3 codes
    localparam logic [2:0] F3Beq  = 3'b000;
    localparam logic [2:0] F3Bne  = 3'b001;
    localparam logic [2:0] F3Blt  = 3'b100;
    localparam logic [2:0] F3Bge  = 3'b101;
    localparam logic [2:0] F3Bltu = 3'b110;
    localparam logic [2:0] F3Bgeu = 3'b111;

endpackage

`default_nettype wire
